//--- fetch_pc.sv
`timescale 1ns/100ps

module fetch_pc (
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_accept,
  input  logic        i_redirect,
  input  logic [63:0] i_redirect_pc,
  output logic [63:0] o_pc
);

  logic [63:0] pc_next;

  // a redirect always wins over a step.
  always_comb begin
    pc_next = o_pc;
    if (i_redirect) begin
      pc_next = {i_redirect_pc[63:2], 2'b00};  // word aligned.
    end else if (i_accept) begin
      pc_next = o_pc + 64'd4;                  // next instruction.
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_pc <= '0;
    end else begin
      o_pc <= pc_next;
    end
  end

endmodule

//--- fetch_pkg.sv
// ***************************************************************************
// fetch front end shared definitions
// ***************************************************************************

package fetch_pkg;

  // memory bus commands.
  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_command_e;

  // transaction tag width, tag zero means no transaction.
  localparam int MEM_TAG_BITS = 4;

  // byte offset inside a 64-bit block.
  localparam int BLOCK_OFFSET_BITS = 3;

  // address bits above this one never reach the tag compare.
  localparam int CACHED_ADDR_BITS = 16;

  // instruction width.
  localparam int INST_BITS = 32;

endpackage

//--- fetch_queue.sv
`timescale 1ns/100ps

module fetch_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                            i_clock,
  input  logic                            i_reset,
  input  logic [63:0]                     i_pc,
  input  logic [63:0]                     i_line_data,
  input  logic                            i_line_valid,
  input  logic                            i_redirect,
  input  logic                            i_inst_ready,
  output logic                            o_accept,
  output logic [fetch_pkg::INST_BITS-1:0] o_inst,
  output logic [63:0]                     o_inst_pc,
  output logic                            o_inst_valid
);

  import fetch_pkg::*;

  localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

  // ************************************************************************
  // storage
  // ************************************************************************

  logic [INST_BITS-1:0] inst_mem [QUEUE_DEPTH];
  logic [63:0]          pc_mem   [QUEUE_DEPTH];

  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [PTR_BITS:0]    count;

  logic                 full;
  logic                 push;
  logic                 pop;
  logic [INST_BITS-1:0] half;

  assign full = count == (PTR_BITS + 1)'(QUEUE_DEPTH);

  // an accept during a redirect belongs to the old stream.
  assign o_accept = i_line_valid && !full && !i_redirect;
  assign push     = o_accept;
  assign pop      = o_inst_valid && i_inst_ready;

  // pc bit 2 picks the upper word of the block.
  assign half = i_pc[2] ? i_line_data[63:32] : i_line_data[31:0];

  assign o_inst       = inst_mem[rd_ptr];
  assign o_inst_pc    = pc_mem[rd_ptr];
  assign o_inst_valid = count != '0;

  always_ff @(posedge i_clock) begin
    if (push) begin
      inst_mem[wr_ptr] <= half;
      pc_mem[wr_ptr]   <= i_pc;
    end
  end

  // ************************************************************************
  // pointers
  // ************************************************************************

  always_ff @(posedge i_clock) begin
    if (i_reset || i_redirect) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;                      // flush.
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

  import fetch_pkg::*;

  localparam int NUM_LINES   = 32;
  localparam int QUEUE_DEPTH = 4;
  localparam int NUM_TESTS   = 6;

  logic                    clock;
  logic                    reset;
  logic                    redirect;
  logic [63:0]             redirect_pc;
  logic                    inst_ready;
  logic                    refuse;
  bus_command_e            mem_command;
  logic [63:0]             mem_addr;
  logic [MEM_TAG_BITS-1:0] mem_response;
  logic [MEM_TAG_BITS-1:0] mem_tag;
  logic [63:0]             mem_data;
  logic [INST_BITS-1:0]    inst;
  logic [63:0]             inst_pc;
  logic                    inst_valid;

  string       test_name   [NUM_TESTS];
  logic [63:0] test_start  [NUM_TESTS];
  int          test_count  [NUM_TESTS];
  bit          test_random [NUM_TESTS];  // random ready.
  bit          test_refuse [NUM_TESTS];  // random memory refusals.

  logic [31:0] rnd;
  int          cycles = 0;
  int          cycle_limit = 100;
  int          tests_passed;
  int          tests_failed;

  tb_clock u_clock (.o_clock(clock));

  tb_memory u_memory (
    .i_clock    (clock),
    .i_reset    (reset),
    .i_command  (mem_command),
    .i_addr     (mem_addr),
    .i_refuse   (refuse),
    .o_response (mem_response),
    .o_tag      (mem_tag),
    .o_data     (mem_data)
  );

  fetch_top #(
    .NUM_LINES   (NUM_LINES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) DUT (
    .i_clock        (clock),
    .i_reset        (reset),
    .o_mem_command  (mem_command),
    .o_mem_addr     (mem_addr),
    .i_mem_response (mem_response),
    .i_mem_tag      (mem_tag),
    .i_mem_data     (mem_data),
    .o_inst         (inst),
    .o_inst_pc      (inst_pc),
    .o_inst_valid   (inst_valid),
    .i_inst_ready   (inst_ready),
    .i_redirect     (redirect),
    .i_redirect_pc  (redirect_pc)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // the word memory holds at an address.
  function automatic logic [31:0] rule_word(input logic [63:0] addr);
    return addr[31:0] ^ 32'hC0DE0000;
  endfunction

  task automatic set_row(input int i, input string name, input logic [63:0] start,
                         input int count, input bit random_ready, input bit refusals);
    test_name[i]   = name;
    test_start[i]  = start;
    test_count[i]  = count;
    test_random[i] = random_ready;
    test_refuse[i] = refusals;
  endtask

  // ************************************************************************
  // test table
  // ************************************************************************

  task automatic fill_table();
    set_row(0, "cold_sequential", 64'h0000, 40, 1'b0, 1'b0);
    set_row(1, "redirect_far",    64'h4A0C, 20, 1'b0, 1'b0);
    set_row(2, "backpressure",    64'h0100, 30, 1'b1, 1'b0);
    set_row(3, "revisit_hits",    64'h0000, 16, 1'b0, 1'b0);
    set_row(4, "mem_refusals",    64'h2000, 30, 1'b0, 1'b1);
    set_row(5, "alias_replace",   64'(NUM_LINES * 8 * 4), 12, 1'b0, 1'b0);  // same indices.
  endtask

  task automatic check_reset_state();
    int errors;
    errors = 0;
    if (inst_valid !== 1'b0) begin
      $display("Mismatch in reset: inst_valid expected 0, actual %b", inst_valid);
      errors++;
    end
    if (mem_command !== BUS_NONE) begin
      $display("Mismatch in reset: mem_command expected %0d, actual %0d",
               BUS_NONE, mem_command);
      errors++;
    end
    $display("reset done, %0d errors", errors);
    if (errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
  endtask

  task automatic run_test(input int t);
    int          n;
    int          errors;
    logic [63:0] exp_pc;
    logic [31:0] exp_inst;
    n           = 0;
    errors      = 0;
    redirect    = 1'b1;
    redirect_pc = test_start[t];
    inst_ready  = 1'b0;
    refuse      = 1'b0;
    @(negedge clock);
    redirect = 1'b0;
    while (n < test_count[t]) begin
      rnd        = next_random(rnd);
      inst_ready = test_random[t] ? rnd[0] : 1'b1;
      rnd        = next_random(rnd);
      refuse     = test_refuse[t] ? rnd[0] : 1'b0;
      // loads go out every cycle, block aligned and below 64 KiB.
      if (mem_command !== BUS_LOAD || mem_addr[2:0] !== 3'b000 ||
          mem_addr[63:16] !== '0) begin
        $display("Bad memory request in %s: command %0d, address %h",
                 test_name[t], mem_command, mem_addr);
        errors++;
      end
      // a transfer happens on the coming rising edge.
      if (inst_valid && inst_ready) begin
        exp_pc   = test_start[t] + (64'(n) << 2);
        exp_inst = rule_word(exp_pc);
        if (inst_pc !== exp_pc) begin
          $display("Mismatch in %s: pc expected %h, actual %h", test_name[t], exp_pc, inst_pc);
          errors++;
        end
        if (inst !== exp_inst) begin
          $display("Mismatch in %s: inst expected %h, actual %h", test_name[t], exp_inst, inst);
          errors++;
        end
        n++;
      end
      @(negedge clock);
    end
    $display("%s done, %0d instructions checked, %0d errors", test_name[t], n, errors);
    if (errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
  endtask

  // ************************************************************************
  // main sequence and timeout
  // ************************************************************************

  initial begin
    int total;
    reset        = 1'b1;
    redirect     = 1'b0;
    redirect_pc  = '0;
    inst_ready   = 1'b0;
    refuse       = 1'b0;
    rnd          = 32'd48;
    tests_passed = 0;
    tests_failed = 0;
    total        = 0;
    fill_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += test_count[t];
    end
    cycle_limit = 40 * total + 100;
    repeat (4) @(negedge clock);
    check_reset_state();
    reset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the instruction stream stalled after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

endmodule

//--- fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
  parameter int NUM_LINES   = 32,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                               i_clock,
  input  logic                               i_reset,

  // memory side.
  output fetch_pkg::bus_command_e            o_mem_command,
  output logic [63:0]                        o_mem_addr,
  input  logic [fetch_pkg::MEM_TAG_BITS-1:0] i_mem_response,
  input  logic [fetch_pkg::MEM_TAG_BITS-1:0] i_mem_tag,
  input  logic [63:0]                        i_mem_data,

  // decode side.
  output logic [fetch_pkg::INST_BITS-1:0]    o_inst,
  output logic [63:0]                        o_inst_pc,
  output logic                               o_inst_valid,
  input  logic                               i_inst_ready,

  // redirect.
  input  logic                               i_redirect,
  input  logic [63:0]                        i_redirect_pc
);

  logic [63:0] pc;
  logic [63:0] line_data;
  logic        line_valid;
  logic        accept;

  fetch_pc u_fetch_pc (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_accept      (accept),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .o_pc          (pc)
  );

  icache #(
    .NUM_LINES (NUM_LINES)
  ) u_icache (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_pc           (pc),
    .i_mem_response (i_mem_response),
    .i_mem_tag      (i_mem_tag),
    .i_mem_data     (i_mem_data),
    .o_mem_command  (o_mem_command),
    .o_mem_addr     (o_mem_addr),
    .o_line_data    (line_data),
    .o_line_valid   (line_valid)
  );

  fetch_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_fetch_queue (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_pc         (pc),
    .i_line_data  (line_data),
    .i_line_valid (line_valid),
    .i_redirect   (i_redirect),
    .i_inst_ready (i_inst_ready),
    .o_accept     (accept),
    .o_inst       (o_inst),
    .o_inst_pc    (o_inst_pc),
    .o_inst_valid (o_inst_valid)
  );

endmodule

//--- flist.f
fetch_pkg.sv
fetch_pc.sv
icache.sv
fetch_queue.sv
fetch_top.sv
tb_clock.sv
tb_memory.sv
fetch_tb.sv

//--- icache.sv
`timescale 1ns/100ps

module icache #(
  parameter int NUM_LINES = 32
) (
  input  logic                               i_clock,
  input  logic                               i_reset,
  input  logic [63:0]                        i_pc,
  input  logic [fetch_pkg::MEM_TAG_BITS-1:0] i_mem_response,
  input  logic [fetch_pkg::MEM_TAG_BITS-1:0] i_mem_tag,
  input  logic [63:0]                        i_mem_data,
  output fetch_pkg::bus_command_e            o_mem_command,
  output logic [63:0]                        o_mem_addr,
  output logic [63:0]                        o_line_data,
  output logic                               o_line_valid
);

  import fetch_pkg::*;

  localparam int IDX_BITS = $clog2(NUM_LINES);
  localparam int BLK_BITS = CACHED_ADDR_BITS - BLOCK_OFFSET_BITS;
  localparam int TAG_BITS = BLK_BITS - IDX_BITS;
  localparam int NUM_TAGS = (1 << MEM_TAG_BITS) - 1;

  // ************************************************************************
  // line storage and stream window
  // ************************************************************************

  logic [63:0]          data_mem [NUM_LINES];
  logic [TAG_BITS-1:0]  tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0] line_ok;

  logic [IDX_BITS-1:0]  head;
  logic [BLK_BITS-1:0]  tail_blk;   // next block of the stream to request.

  // memory tag table, one entry per nonzero transaction tag.
  logic [NUM_TAGS:1]    tt_valid;
  logic [IDX_BITS-1:0]  tt_idx [1:NUM_TAGS];
  logic [TAG_BITS-1:0]  tt_tag [1:NUM_TAGS];

  logic [BLK_BITS-1:0]  pc_blk;
  logic [IDX_BITS-1:0]  idx;
  logic [TAG_BITS-1:0]  tag;
  logic [IDX_BITS-1:0]  tail_idx;
  logic [IDX_BITS-1:0]  tail_next_idx;
  logic [IDX_BITS-1:0]  dist_pc;
  logic [IDX_BITS-1:0]  dist_tail;
  logic                 tag_match;
  logic                 in_window;
  logic                 stream;

  logic [BLK_BITS-1:0]  req_blk;
  logic [IDX_BITS-1:0]  req_idx;
  logic [TAG_BITS-1:0]  req_tag;
  logic                 want;
  logic                 accepted;
  logic                 record;

  logic                 ret_ok;
  logic [IDX_BITS-1:0]  ret_idx;
  logic [TAG_BITS-1:0]  ret_tag;

  assign pc_blk   = i_pc[CACHED_ADDR_BITS-1:BLOCK_OFFSET_BITS];
  assign idx      = pc_blk[IDX_BITS-1:0];
  assign tag      = pc_blk[BLK_BITS-1:IDX_BITS];
  assign tail_idx = tail_blk[IDX_BITS-1:0];

  assign tail_next_idx = tail_idx + 1'b1;
  assign dist_pc       = idx - head;
  assign dist_tail     = tail_idx - head;

  // lines head up to tail minus one are already requested.
  assign in_window = dist_pc < dist_tail;
  assign tag_match = tag_mem[idx] == tag;
  assign stream    = in_window && tag_match;

  assign o_line_data  = data_mem[idx];
  assign o_line_valid = line_ok[idx] && tag_match;

  // ************************************************************************
  // request side
  // ************************************************************************

  assign req_blk = stream ? tail_blk : pc_blk;
  assign req_idx = req_blk[IDX_BITS-1:0];
  assign req_tag = req_blk[BLK_BITS-1:IDX_BITS];

  assign o_mem_addr = {{(64 - CACHED_ADDR_BITS){1'b0}}, req_blk, {BLOCK_OFFSET_BITS{1'b0}}};

  // a full window must not overwrite the line behind the pc.
  assign want     = !(stream && (tail_next_idx == head));
  assign accepted = (o_mem_command == BUS_LOAD) && (i_mem_response != '0);
  assign record   = accepted && want;

  // return lookup, data only lands if the line still holds that tag.
  always_comb begin
    ret_ok  = 1'b0;
    ret_idx = '0;
    ret_tag = '0;
    if (i_mem_tag != '0) begin
      ret_idx = tt_idx[i_mem_tag];
      ret_tag = tt_tag[i_mem_tag];
      ret_ok  = tt_valid[i_mem_tag] && (tag_mem[ret_idx] == ret_tag);
    end
  end

  // ************************************************************************
  // state
  // ************************************************************************

  always_ff @(posedge i_clock) begin
    if (ret_ok) begin
      data_mem[ret_idx] <= i_mem_data;
    end
    if (record) begin
      tag_mem[req_idx] <= req_tag;       // claim the line at request time.
    end
    if (accepted) begin
      tt_idx[i_mem_response] <= req_idx;
      tt_tag[i_mem_response] <= req_tag;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      line_ok       <= '0;
      tt_valid      <= '0;
      head          <= '0;
      tail_blk      <= '0;
      o_mem_command <= BUS_NONE;
    end else begin
      o_mem_command <= BUS_LOAD;
      head          <= idx;

      if (ret_ok) begin
        line_ok[ret_idx] <= 1'b1;
      end
      // a new tag on the line overrides a return in the same cycle.
      if (record && (tag_mem[req_idx] != req_tag)) begin
        line_ok[req_idx] <= 1'b0;
      end

      if (i_mem_tag != '0) begin
        tt_valid[i_mem_tag] <= 1'b0;     // entry done either way.
      end
      if (accepted) begin
        tt_valid[i_mem_response] <= want;
      end

      if (stream) begin
        if (record) begin
          tail_blk <= tail_blk + 1'b1;
        end
      end else if (accepted) begin
        tail_blk <= pc_blk + 1'b1;       // restart, pc line is on its way.
      end else begin
        tail_blk <= pc_blk;              // empty window, ask again.
      end
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f flist.f \
    --top-module fetch_tb -o fetch_sim \
  && ./obj_dir/fetch_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
  && echo "simulation run ok" \
  || { echo "simulation run not ok"; exit 1; }

//--- tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD = 20
) (
  output logic o_clock
);

  initial begin
    o_clock = 1'b0;
    forever #(HALF_PERIOD) o_clock = ~o_clock;  // 40 ns period.
  end

endmodule

//--- tb_memory.sv
`timescale 1ns/100ps

module tb_memory #(
  parameter int LATENCY = 6
) (
  input  logic                               i_clock,
  input  logic                               i_reset,
  input  fetch_pkg::bus_command_e            i_command,
  input  logic [63:0]                        i_addr,
  input  logic                               i_refuse,
  output logic [fetch_pkg::MEM_TAG_BITS-1:0] o_response,
  output logic [fetch_pkg::MEM_TAG_BITS-1:0] o_tag,
  output logic [63:0]                        o_data
);

  import fetch_pkg::*;

  logic [MEM_TAG_BITS-1:0] next_tag;
  logic [MEM_TAG_BITS-1:0] pipe_tag  [LATENCY];
  logic [63:0]             pipe_data [LATENCY];
  logic [63:0]             block_addr;

  // contents of memory, one word per address.
  function automatic logic [31:0] code_word(input logic [63:0] addr);
    return addr[31:0] ^ 32'hC0DE0000;
  endfunction

  assign block_addr = {i_addr[63:3], 3'b000};

  // a load is accepted in the cycle it is seen.
  assign o_response = (i_command == BUS_LOAD && !i_refuse) ? next_tag : '0;

  // ************************************************************************
  // fixed latency return pipe
  // ************************************************************************

  always @(posedge i_clock) begin
    if (i_reset) begin
      next_tag <= MEM_TAG_BITS'(1);
      for (int i = 0; i < LATENCY; i++) begin
        pipe_tag[i]  <= '0;
        pipe_data[i] <= '0;
      end
    end else begin
      pipe_tag[0]  <= o_response;                 // zero marks an empty slot.
      pipe_data[0] <= {code_word(block_addr + 64'd4), code_word(block_addr)};
      for (int i = 1; i < LATENCY; i++) begin
        pipe_tag[i]  <= pipe_tag[i-1];
        pipe_data[i] <= pipe_data[i-1];
      end
      if (o_response != '0) begin
        next_tag <= (next_tag == '1) ? MEM_TAG_BITS'(1) : next_tag + 1'b1;
      end
    end
  end

  // returned data moves on the falling edge.
  always @(negedge i_clock) begin
    o_tag  <= pipe_tag[LATENCY-1];
    o_data <= pipe_data[LATENCY-1];
  end

endmodule
